// File: Makefile
# Verilator build and run for the fuse/lifecycle service controller.

SRCS := $(shell cat build.f)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes.
obj_dir/Vtb_fc_lcc_svc: build.f $(SRCS)
	verilator --binary --assert --top-module tb_fc_lcc_svc -f build.f \
	  -Mdir obj_dir -o Vtb_fc_lcc_svc

# Assertion failures are counted by the testbench, so the run must not stop
# at the first one.
run: obj_dir/Vtb_fc_lcc_svc
	./obj_dir/Vtb_fc_lcc_svc +verilator+error+limit+1000 > sim.log 2>&1; true
	cat sim.log
	grep -q '^sim passed$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
rtl/svc_pkg.sv
rtl/svc_ctrl_if.sv
rtl/svc_ctrl_regs.sv
rtl/svc_reset_seq.sv
rtl/svc_fault_inject.sv
rtl/fc_lcc_svc_top.sv
tb/fc_lcc_svc_chk.sv
tb/tb_fc_lcc_svc.sv

// File: rtl/fc_lcc_svc_top.sv
// --------------------
// Fuse and lifecycle controller service block. Connects the command
// register block, the reset sequencer and the OTP fault injector.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module fc_lcc_svc_top (
  input  logic                          clk,
  input  logic                          cptra_rst_b,
  // Command strobe, valid for a single cycle.
  input  logic                          cmd_valid_i,
  input  svc_pkg::svc_cmd_t             cmd_i,
  input  logic                          clk_byp_ack_i,
  input  logic                          zer_write_i,
  // Locked partition contents and digest status.
  input  svc_pkg::otp_word_t            part_word_i [svc_pkg::NUM_PARTS],
  input  logic [svc_pkg::NUM_PARTS-1:0] part_locked_i,
  // Steering outputs.
  output logic                          fc_lcc_rst_b_o,
  output svc_pkg::clk_mhz_t             clk_sel_o,
  output logic                          clk_switch_req_o,
  output logic                          esc0_o,
  output logic                          esc1_o,
  output logic                          fc_escalate_o,
  output logic                          sva_en_o,
  output svc_pkg::otp_word_t            fault_word_o [svc_pkg::NUM_PARTS],
  output logic                          fault_active_o
);

  svc_ctrl_if ctrl_if ();

  // --------------------
  // Command decode
  // --------------------
  svc_ctrl_regs i_svc_ctrl_regs (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .ctrl             (ctrl_if.regs),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o),
    .esc0_o           (esc0_o),
    .esc1_o           (esc1_o),
    .fc_escalate_o    (fc_escalate_o),
    .sva_en_o         (sva_en_o)
  );

  // --------------------
  // Reset and faults
  // --------------------
  svc_reset_seq i_svc_reset_seq (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .ctrl           (ctrl_if.seq),
    .zer_write_i    (zer_write_i),
    .fc_lcc_rst_b_o (fc_lcc_rst_b_o)
  );

  svc_fault_inject i_svc_fault_inject (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .ctrl           (ctrl_if.inj),
    .part_word_i    (part_word_i),
    .part_locked_i  (part_locked_i),
    .fault_word_o   (fault_word_o),
    .fault_active_o (fault_active_o)
  );

endmodule

`default_nettype wire

// File: rtl/svc_ctrl_if.sv
// --------------------
// Decoded control from the register block to the reset sequencer
// and the OTP fault injector.
// --------------------

`timescale 1ns/1ns
`default_nettype none

interface svc_ctrl_if;

  // One-cycle strobe requesting a manual fuse/lifecycle reset.
  logic rst_cmd;
  // Level that arms reset on zeroization writes.
  logic rst_on_zer_en;
  // One-cycle strobes for the two fault kinds.
  logic corr_fault_cmd;
  logic uncorr_fault_cmd;

  modport regs (
    output rst_cmd,
    output rst_on_zer_en,
    output corr_fault_cmd,
    output uncorr_fault_cmd
  );

  modport seq (input rst_cmd, input rst_on_zer_en);

  modport inj (input corr_fault_cmd, input uncorr_fault_cmd);

endinterface

`default_nettype wire

// File: rtl/svc_ctrl_regs.sv
// --------------------
// Command decoder and control register block. Keeps the clock selection,
// the external clock request, escalation and assertion flags, and the
// reset-on-zeroization arm.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module svc_ctrl_regs (
  input  logic               clk,
  input  logic               cptra_rst_b,
  input  logic               cmd_valid_i,
  input  svc_pkg::svc_cmd_t  cmd_i,
  input  logic               clk_byp_ack_i,
  svc_ctrl_if.regs           ctrl,
  output svc_pkg::clk_mhz_t  clk_sel_o,
  output logic               clk_switch_req_o,
  output logic               esc0_o,
  output logic               esc1_o,
  output logic               fc_escalate_o,
  output logic               sva_en_o
);

  import svc_pkg::*;

  clk_mhz_t clk_sel_q;
  logic     ext_clk_req_q;
  logic     esc0_q;
  logic     esc1_q;
  logic     fc_esc_q;
  logic     sva_en_q;
  logic     rst_on_zer_q;

  // --------------------
  // Strobes to neighbours
  // --------------------
  // These follow the command directly so the neighbour samples them on
  // the same edge as the command itself.
  assign ctrl.rst_cmd          = cmd_valid_i && (cmd_i == CMD_FC_LCC_RESET);
  assign ctrl.corr_fault_cmd   = cmd_valid_i && (cmd_i == CMD_FC_LCC_CORRECTABLE_FAULT);
  assign ctrl.uncorr_fault_cmd = cmd_valid_i && (cmd_i == CMD_FC_LCC_UNCORRECTABLE_FAULT);
  assign ctrl.rst_on_zer_en    = rst_on_zer_q;

  // The switch request is visible only while the bypass is acknowledged.
  assign clk_switch_req_o = clk_byp_ack_i && ext_clk_req_q;

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q     <= CLK_MHZ_DEFAULT;
      ext_clk_req_q <= 1'b0;
      esc0_q        <= 1'b0;
      esc1_q        <= 1'b0;
      fc_esc_q      <= 1'b0;
      sva_en_q      <= 1'b1;
      rst_on_zer_q  <= 1'b0;
    end else begin
      // Drop the request once it has been seen with the acknowledge.
      // A clock command below overrides this in the same cycle.
      if (clk_switch_req_o) begin
        ext_clk_req_q <= 1'b0;
      end
      if (cmd_valid_i) begin
        case (cmd_i)
          CMD_FC_LCC_EN_RESET_WHILE_0ING:  rst_on_zer_q <= 1'b1;
          CMD_FC_LCC_DIS_RESET_WHILE_0ING: rst_on_zer_q <= 1'b0;
          CMD_LC_DISABLE_SVA:              sva_en_q     <= 1'b0;
          CMD_LC_ENABLE_SVA:               sva_en_q     <= 1'b1;
          CMD_FC_LCC_EXT_CLK_500MHZ: begin
            clk_sel_q     <= CLK_MHZ_500;
            ext_clk_req_q <= 1'b1;
          end
          CMD_FC_LCC_EXT_CLK_160MHZ: begin
            clk_sel_q     <= CLK_MHZ_160;
            ext_clk_req_q <= 1'b1;
          end
          CMD_FC_LCC_EXT_CLK_400MHZ: begin
            clk_sel_q     <= CLK_MHZ_400;
            ext_clk_req_q <= 1'b1;
          end
          CMD_FC_LCC_EXT_CLK_1000MHZ: begin
            clk_sel_q     <= CLK_MHZ_1000;
            ext_clk_req_q <= 1'b1;
          end
          CMD_LC_TRIGGER_ESCALATION0:     esc0_q   <= 1'b1;
          CMD_LC_TRIGGER_ESCALATION0_DIS: esc0_q   <= 1'b0;
          CMD_LC_TRIGGER_ESCALATION1:     esc1_q   <= 1'b1;
          CMD_LC_TRIGGER_ESCALATION1_DIS: esc1_q   <= 1'b0;
          // Fuse controller escalation has no release command.
          CMD_FC_TRIGGER_ESCALATION:      fc_esc_q <= 1'b1;
          default: begin
            // Unknown codes and codes owned by other blocks leave state alone.
          end
        endcase
      end
    end
  end

  assign clk_sel_o     = clk_sel_q;
  assign esc0_o        = esc0_q;
  assign esc1_o        = esc1_q;
  assign fc_escalate_o = fc_esc_q;
  assign sva_en_o      = sva_en_q;

endmodule

`default_nettype wire

// File: rtl/svc_fault_inject.sv
// --------------------
// One-shot OTP fault injector for the locked secret partitions.
// Latches the faulted partition words on the first fault command.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module svc_fault_inject (
  input  logic                       clk,
  input  logic                       cptra_rst_b,
  svc_ctrl_if.inj                    ctrl,
  input  svc_pkg::otp_word_t         part_word_i [svc_pkg::NUM_PARTS],
  input  logic [svc_pkg::NUM_PARTS-1:0] part_locked_i,
  output svc_pkg::otp_word_t         fault_word_o [svc_pkg::NUM_PARTS],
  output logic                       fault_active_o
);

  import svc_pkg::*;

  logic      fault_active_q;
  logic      capture;
  otp_word_t corr_word   [NUM_PARTS];
  otp_word_t uncorr_word [NUM_PARTS];
  otp_word_t fault_word_q [NUM_PARTS];

  // --------------------
  // Faulted word generation
  // --------------------
  // A partition counts as locked when its digest is nonzero. Unlocked
  // partitions pass through untouched in both fault modes.
  for (genvar i = 0; i < NUM_PARTS; i++) begin : g_part
    assign corr_word[i]   = {part_word_i[i][15:1], part_word_i[i][0] ^ part_locked_i[i]};
    assign uncorr_word[i] = part_word_i[i] ^ {16{part_locked_i[i]}};
  end

  // Only the first fault command after reset is taken.
  assign capture = (ctrl.corr_fault_cmd || ctrl.uncorr_fault_cmd) && !fault_active_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
    end else if (capture) begin
      fault_active_q <= 1'b1;
    end
  end

  // --------------------
  // Captured words
  // --------------------
  always_ff @(posedge clk) begin
    if (capture) begin
      for (int i = 0; i < NUM_PARTS; i++) begin
        if (ctrl.corr_fault_cmd) begin
          fault_word_q[i] <= corr_word[i];
        end else begin
          fault_word_q[i] <= uncorr_word[i];
        end
      end
    end
  end

  assign fault_word_o   = fault_word_q;
  assign fault_active_o = fault_active_q;

endmodule

`default_nettype wire

// File: rtl/svc_pkg.sv
// --------------------
// Service controller package for the fuse and lifecycle controller subsystem.
// Holds command codes, OTP word and clock types, and reset pulse timing.
// --------------------

`default_nettype none

package svc_pkg;

  // --------------------
  // Command codes
  // --------------------
  typedef logic [7:0] svc_cmd_t;

  localparam svc_cmd_t CMD_FC_LCC_RESET                = 8'h10;
  localparam svc_cmd_t CMD_FC_LCC_EN_RESET_WHILE_0ING  = 8'h11;
  localparam svc_cmd_t CMD_FC_LCC_DIS_RESET_WHILE_0ING = 8'h12;
  localparam svc_cmd_t CMD_LC_DISABLE_SVA              = 8'h13;
  localparam svc_cmd_t CMD_LC_ENABLE_SVA               = 8'h14;
  localparam svc_cmd_t CMD_FC_LCC_EXT_CLK_500MHZ       = 8'h20;
  localparam svc_cmd_t CMD_FC_LCC_EXT_CLK_160MHZ       = 8'h21;
  localparam svc_cmd_t CMD_FC_LCC_EXT_CLK_400MHZ       = 8'h22;
  localparam svc_cmd_t CMD_FC_LCC_EXT_CLK_1000MHZ      = 8'h23;
  localparam svc_cmd_t CMD_LC_TRIGGER_ESCALATION0      = 8'h30;
  localparam svc_cmd_t CMD_LC_TRIGGER_ESCALATION0_DIS  = 8'h31;
  localparam svc_cmd_t CMD_LC_TRIGGER_ESCALATION1      = 8'h32;
  localparam svc_cmd_t CMD_LC_TRIGGER_ESCALATION1_DIS  = 8'h33;
  localparam svc_cmd_t CMD_FC_TRIGGER_ESCALATION       = 8'h34;
  localparam svc_cmd_t CMD_FC_LCC_CORRECTABLE_FAULT    = 8'h40;
  localparam svc_cmd_t CMD_FC_LCC_UNCORRECTABLE_FAULT  = 8'h41;

  // --------------------
  // External clock selection
  // --------------------
  // Frequency in MHz; 10 bits cover up to 1023 MHz.
  typedef logic [9:0] clk_mhz_t;

  localparam clk_mhz_t CLK_MHZ_160     = 10'd160;
  localparam clk_mhz_t CLK_MHZ_400     = 10'd400;
  localparam clk_mhz_t CLK_MHZ_500     = 10'd500;
  localparam clk_mhz_t CLK_MHZ_1000    = 10'd1000;
  localparam clk_mhz_t CLK_MHZ_DEFAULT = CLK_MHZ_1000;

  // --------------------
  // OTP partitions
  // --------------------
  typedef logic [15:0] otp_word_t;

  // Number of locked secret partitions that can be faulted.
  localparam int NUM_PARTS = 7;

  // --------------------
  // Reset pulse
  // --------------------
  typedef logic [3:0] rst_cnt_t;

  // The counter runs from 0 up to this value, so the pulse spans 11 cycles.
  localparam rst_cnt_t RST_PULSE_LAST = 4'd10;

endpackage

`default_nettype wire

// File: rtl/svc_reset_seq.sv
// --------------------
// Fuse/lifecycle reset sequencer. Holds the reset low for a fixed
// number of cycles after a command or an armed zeroization write.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module svc_reset_seq (
  input  logic     clk,
  input  logic     cptra_rst_b,
  svc_ctrl_if.seq  ctrl,
  input  logic     zer_write_i,
  output logic     fc_lcc_rst_b_o
);

  import svc_pkg::*;

  logic     active_q;
  rst_cnt_t cnt_q;
  logic     trigger;

  // A zeroization write only counts while the arm is set.
  assign trigger = ctrl.rst_cmd || (zer_write_i && ctrl.rst_on_zer_en);

  // --------------------
  // Pulse counter
  // --------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (active_q) begin
      // Triggers during a running pulse are dropped, so the pulse
      // length never stretches.
      if (cnt_q == RST_PULSE_LAST) begin
        active_q <= 1'b0;
        cnt_q    <= '0;
      end else begin
        cnt_q <= cnt_q + rst_cnt_t'(1);
      end
    end else if (trigger) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
    end
  end

  // Reset is active low, so it drops as soon as the pulse starts.
  assign fc_lcc_rst_b_o = !active_q;

endmodule

`default_nettype wire

// File: tb/fc_lcc_svc_chk.sv
// --------------------
// Bound checks for the service controller: reset pulse length,
// clock switch request clearing and captured fault word stability.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module fc_lcc_svc_chk (
  input logic                      clk,
  input logic                      cptra_rst_b,
  input logic                      cmd_valid_i,
  input svc_pkg::svc_cmd_t         cmd_i,
  input logic                      fc_lcc_rst_b_i,
  input logic                      clk_switch_req_i,
  input svc_pkg::otp_word_t        fault_word_i [svc_pkg::NUM_PARTS],
  input logic                      fault_active_i
);

  import svc_pkg::*;

  int unsigned rst_len_errs = 0;
  int unsigned clk_req_errs = 0;
  int unsigned fault_word_errs = 0;

  logic [7:0]              low_len;
  logic                    clk_cmd;
  logic [NUM_PARTS*16-1:0] words_flat;

  // Number of edges at which the fuse/lifecycle reset was seen low.
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      low_len <= '0;
    end else if (!fc_lcc_rst_b_i) begin
      low_len <= low_len + 8'd1;
    end else begin
      low_len <= '0;
    end
  end

  assign clk_cmd = cmd_valid_i && (cmd_i inside {CMD_FC_LCC_EXT_CLK_500MHZ,
    CMD_FC_LCC_EXT_CLK_160MHZ, CMD_FC_LCC_EXT_CLK_400MHZ, CMD_FC_LCC_EXT_CLK_1000MHZ});

  always_comb begin
    for (int i = 0; i < NUM_PARTS; i++) begin
      words_flat[i*16 +: 16] = fault_word_i[i];
    end
  end

  // --------------------
  // Properties
  // --------------------
  // Every pulse lasts 11 cycles, even with a second trigger in the middle.
  a_rst_len: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(fc_lcc_rst_b_i) |-> (low_len == 8'd11))
    else begin
      rst_len_errs++;
      $error("fuse/lifecycle reset pulse lasted %0d cycles", low_len);
    end

  a_clk_req_clear: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (clk_switch_req_i && !clk_cmd) |=> !clk_switch_req_i)
    else begin
      clk_req_errs++;
      $error("clock switch request stayed high after the acknowledge");
    end

  a_fault_stable: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $past(fault_active_i) |-> (fault_active_i && (words_flat == $past(words_flat))))
    else begin
      fault_word_errs++;
      $error("captured fault words changed after the first fault command");
    end

endmodule

`default_nettype wire

// File: tb/tb_fc_lcc_svc.sv
// --------------------
// Testbench for the fuse/lifecycle service controller. Drives commands,
// compares outputs against a behavioral model and sums bound check errors.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module tb_fc_lcc_svc;

  import svc_pkg::*;

  logic                 clk;
  logic                 cptra_rst_b;
  logic                 cmd_valid_i;
  svc_cmd_t             cmd_i;
  logic                 clk_byp_ack_i;
  logic                 zer_write_i;
  otp_word_t            part_word_i [NUM_PARTS];
  logic [NUM_PARTS-1:0] part_locked_i;
  logic                 fc_lcc_rst_b_o;
  clk_mhz_t             clk_sel_o;
  logic                 clk_switch_req_o;
  logic                 esc0_o;
  logic                 esc1_o;
  logic                 fc_escalate_o;
  logic                 sva_en_o;
  otp_word_t            fault_word_o [NUM_PARTS];
  logic                 fault_active_o;

  int          err_cnt = 0;
  int          cyc = 0;
  int          start;
  int unsigned chk_errs;
  logic [31:0] rnd;

  // Model of the register state.
  logic       m_esc0;
  logic       m_esc1;
  logic       m_fc_esc;
  logic       m_sva;
  logic [9:0] m_clk_sel;
  otp_word_t  exp_word [NUM_PARTS];

  svc_cmd_t flag_cmds [8] = '{CMD_LC_TRIGGER_ESCALATION0, CMD_LC_TRIGGER_ESCALATION1,
    CMD_LC_TRIGGER_ESCALATION0_DIS, CMD_LC_TRIGGER_ESCALATION1_DIS,
    CMD_FC_TRIGGER_ESCALATION, 8'h7f, CMD_LC_DISABLE_SVA, CMD_LC_ENABLE_SVA};
  svc_cmd_t clk_cmds [4] = '{CMD_FC_LCC_EXT_CLK_500MHZ, CMD_FC_LCC_EXT_CLK_160MHZ,
    CMD_FC_LCC_EXT_CLK_400MHZ, CMD_FC_LCC_EXT_CLK_1000MHZ};

  fc_lcc_svc_top i_fc_lcc_svc_top (.*);

  bind fc_lcc_svc_top fc_lcc_svc_chk i_chk (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .fc_lcc_rst_b_i   (fc_lcc_rst_b_o),
    .clk_switch_req_i (clk_switch_req_o),
    .fault_word_i     (fault_word_o),
    .fault_active_i   (fault_active_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cyc = cyc + 1;

  // --------------------
  // Checks and model
  // --------------------
  task automatic check_flag(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_regs();
    check_word("clk_sel_o", 16'(clk_sel_o), 16'(m_clk_sel));
    check_flag("esc0_o", esc0_o, m_esc0);
    check_flag("esc1_o", esc1_o, m_esc1);
    check_flag("fc_escalate_o", fc_escalate_o, m_fc_esc);
    check_flag("sva_en_o", sva_en_o, m_sva);
  endtask

  task automatic model_cmd(input svc_cmd_t c);
    case (c)
      CMD_LC_DISABLE_SVA:             m_sva     = 1'b0;
      CMD_LC_ENABLE_SVA:              m_sva     = 1'b1;
      CMD_FC_LCC_EXT_CLK_500MHZ:      m_clk_sel = 10'd500;
      CMD_FC_LCC_EXT_CLK_160MHZ:      m_clk_sel = 10'd160;
      CMD_FC_LCC_EXT_CLK_400MHZ:      m_clk_sel = 10'd400;
      CMD_FC_LCC_EXT_CLK_1000MHZ:     m_clk_sel = 10'd1000;
      CMD_LC_TRIGGER_ESCALATION0:     m_esc0    = 1'b1;
      CMD_LC_TRIGGER_ESCALATION0_DIS: m_esc0    = 1'b0;
      CMD_LC_TRIGGER_ESCALATION1:     m_esc1    = 1'b1;
      CMD_LC_TRIGGER_ESCALATION1_DIS: m_esc1    = 1'b0;
      CMD_FC_TRIGGER_ESCALATION:      m_fc_esc  = 1'b1;
      default: begin
      end
    endcase
  endtask

  // Locked partitions get bit 0 flipped, or every bit for an uncorrectable fault.
  function automatic otp_word_t faulted_word(input otp_word_t w, input logic locked,
                                             input logic uncorr);
    if (!locked) begin
      return w;
    end
    if (uncorr) begin
      return ~w;
    end
    return w ^ 16'h0001;
  endfunction

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic apply_reset();
    cptra_rst_b = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    cptra_rst_b = 1'b1;
    m_esc0    = 1'b0;
    m_esc1    = 1'b0;
    m_fc_esc  = 1'b0;
    m_sva     = 1'b1;
    m_clk_sel = 10'd1000;
  endtask

  task automatic send_cmd(input svc_cmd_t c);
    cmd_valid_i = 1'b1;
    cmd_i       = c;
    @(posedge clk);
    #1;
    cmd_valid_i = 1'b0;
    cmd_i       = 8'h00;
    model_cmd(c);
  endtask

  task automatic pulse_zer_write();
    zer_write_i = 1'b1;
    @(posedge clk);
    #1;
    zer_write_i = 1'b0;
  endtask

  task automatic wait_rst_release(input int limit);
    int n;
    n = 0;
    while (fc_lcc_rst_b_o !== 1'b1 && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (fc_lcc_rst_b_o !== 1'b1) begin
      $display("Timeout: fuse/lifecycle reset still low after %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  endtask

  task automatic load_partitions();
    for (int i = 0; i < NUM_PARTS; i++) begin
      rnd = $urandom();
      part_word_i[i] = rnd[15:0];
    end
    rnd = $urandom();
    // Keep one locked and one unlocked partition in every draw.
    part_locked_i = {rnd[NUM_PARTS-1:2], 2'b01};
  endtask

  task automatic fault_and_check(input svc_cmd_t c, input logic uncorr);
    for (int i = 0; i < NUM_PARTS; i++) begin
      exp_word[i] = faulted_word(part_word_i[i], part_locked_i[i], uncorr);
    end
    send_cmd(c);
    check_flag("fault_active_o", fault_active_o, 1'b1);
    for (int i = 0; i < NUM_PARTS; i++) begin
      check_word($sformatf("fault_word_o[%0d]", i), fault_word_o[i], exp_word[i]);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    clk           = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = 8'h00;
    clk_byp_ack_i = 1'b0;
    zer_write_i   = 1'b0;
    part_locked_i = '0;
    for (int i = 0; i < NUM_PARTS; i++) begin
      part_word_i[i] = 16'h0000;
    end
    void'($urandom(32'h6c6e));
    apply_reset();
    check_regs();
    check_flag("fc_lcc_rst_b_o", fc_lcc_rst_b_o, 1'b1);
    check_flag("clk_switch_req_o", clk_switch_req_o, 1'b0);
    check_flag("fault_active_o", fault_active_o, 1'b0);

    // Manual reset with a second command in the middle of the pulse.
    send_cmd(CMD_FC_LCC_RESET);
    check_flag("fc_lcc_rst_b_o", fc_lcc_rst_b_o, 1'b0);
    start = cyc;
    repeat (3) @(posedge clk);
    #1;
    send_cmd(CMD_FC_LCC_RESET);
    wait_rst_release(20);
    check_word("reset pulse length", 16'(cyc - start), 16'd11);

    // Zeroization writes only reset while armed.
    pulse_zer_write();
    check_flag("fc_lcc_rst_b_o unarmed", fc_lcc_rst_b_o, 1'b1);
    send_cmd(CMD_FC_LCC_EN_RESET_WHILE_0ING);
    pulse_zer_write();
    check_flag("fc_lcc_rst_b_o armed", fc_lcc_rst_b_o, 1'b0);
    start = cyc;
    wait_rst_release(20);
    check_word("zeroization pulse length", 16'(cyc - start), 16'd11);
    send_cmd(CMD_FC_LCC_DIS_RESET_WHILE_0ING);
    pulse_zer_write();
    check_flag("fc_lcc_rst_b_o disarmed", fc_lcc_rst_b_o, 1'b1);

    // Each clock command, then the acknowledge that clears its request.
    // The acknowledge stays up one more cycle, so a request that failed
    // to clear would still be visible.
    foreach (clk_cmds[k]) begin
      send_cmd(clk_cmds[k]);
      check_regs();
      check_flag("clk_switch_req_o before ack", clk_switch_req_o, 1'b0);
      clk_byp_ack_i = 1'b1;
      #1;
      check_flag("clk_switch_req_o with ack", clk_switch_req_o, 1'b1);
      @(posedge clk);
      #1;
      check_flag("clk_switch_req_o after ack", clk_switch_req_o, 1'b0);
      @(posedge clk);
      #1;
      clk_byp_ack_i = 1'b0;
    end
    // A clock command in the clearing cycle keeps the request up.
    send_cmd(CMD_FC_LCC_EXT_CLK_500MHZ);
    clk_byp_ack_i = 1'b1;
    send_cmd(CMD_FC_LCC_EXT_CLK_1000MHZ);
    check_regs();
    check_flag("clk_switch_req_o re-armed", clk_switch_req_o, 1'b1);
    @(posedge clk);
    #1;
    check_flag("clk_switch_req_o cleared", clk_switch_req_o, 1'b0);
    @(posedge clk);
    #1;
    clk_byp_ack_i = 1'b0;

    foreach (flag_cmds[k]) begin
      send_cmd(flag_cmds[k]);
      check_regs();
    end

    // Correctable fault first, then a later command that must be ignored.
    load_partitions();
    fault_and_check(CMD_FC_LCC_CORRECTABLE_FAULT, 1'b0);
    load_partitions();
    send_cmd(CMD_FC_LCC_UNCORRECTABLE_FAULT);
    for (int i = 0; i < NUM_PARTS; i++) begin
      check_word($sformatf("held fault_word_o[%0d]", i), fault_word_o[i], exp_word[i]);
    end
    apply_reset();
    check_flag("fault_active_o after reset", fault_active_o, 1'b0);
    load_partitions();
    fault_and_check(CMD_FC_LCC_UNCORRECTABLE_FAULT, 1'b1);
    send_cmd(CMD_FC_LCC_CORRECTABLE_FAULT);
    repeat (2) @(posedge clk);
    #1;

    chk_errs = i_fc_lcc_svc_top.i_chk.rst_len_errs + i_fc_lcc_svc_top.i_chk.clk_req_errs
             + i_fc_lcc_svc_top.i_chk.fault_word_errs;
    $display("Errors: %0d model checks, %0d assertions", err_cnt, chk_errs);
    if (err_cnt == 0 && chk_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
